// File: common/fpu_pkg.sv
package fpu_pkg;

    // Format widths
    localparam int FP32_W = 32;
    localparam int BF16_W = 16;
    localparam int EXP_W  = 8;

    // Canonical positive quiet NaNs
    localparam logic [FP32_W-1:0] FP32_QNAN = 32'h7FC0_0000;
    localparam logic [BF16_W-1:0] BF16_QNAN = 16'h7FC0;

    // Bit positions in flags and FPCSR
    localparam int FLAG_NV = 3;    // Invalid
    localparam int FLAG_OF = 2;    // Overflow
    localparam int FLAG_UF = 1;    // Underflow
    localparam int FLAG_NX = 0;    // Inexact

    // One-bit opcode
    localparam logic OP_WIDEN  = 1'b0;    // BF16 -> FP32
    localparam logic OP_NARROW = 1'b1;    // FP32 -> BF16

    // FP32 operand split into its fields
    typedef struct packed {
        logic                      sign;
        logic [EXP_W-1:0]          exp;
        logic [FP32_W-EXP_W-2:0]   man;    // 23 bits
    } fp32_fields_t;

    // Same word seen as two BF16 halves
    // Only lo carries a widening operand
    typedef struct packed {
        logic [BF16_W-1:0] hi;
        logic [BF16_W-1:0] lo;
    } bf16_pair_t;

    // Operand word, decoded per opcode
    typedef union packed {
        fp32_fields_t fp32;    // Narrowing view
        bf16_pair_t   bf16;    // Widening view
    } operand_u;

    // Request into the unit, 33 bits
    typedef struct packed {
        logic     op;         // OP_WIDEN or OP_NARROW
        operand_u operand;
    } cvt_req_t;

    // Response out of the unit, 36 bits
    // Narrowing results sit zero-extended in the low half
    typedef struct packed {
        logic [FP32_W-1:0] result;
        logic [3:0]        flags;
    } cvt_rsp_t;

endpackage

// File: convert/bf16_to_fp32.sv
`timescale 1ns/1ps

module bf16_to_fp32 (
    input  logic                        gated_clk,
    input  logic                        reset,
    // Request side
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  logic [fpu_pkg::BF16_W-1:0]  operand_i,    // BF16 operand
    // Response side
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output fpu_pkg::cvt_rsp_t           rsp_o
);

    logic              sign;
    logic [7:0]        exp;
    logic [6:0]        man;
    logic              is_nan;
    logic              is_snan;
    logic              in_fire;
    logic              valid_q;
    fpu_pkg::cvt_rsp_t rsp_d;
    fpu_pkg::cvt_rsp_t rsp_q;

    assign sign = operand_i[15];
    assign exp  = operand_i[14:7];
    assign man  = operand_i[6:0];

    assign is_nan  = (exp == 8'hFF) && (man != 7'd0);
    assign is_snan = is_nan && !man[6];    // Quiet bit clear

    // Widening is exact, so only NaNs need care
    always_comb begin
        rsp_d = '0;
        if (is_nan) begin
            rsp_d.result = fpu_pkg::FP32_QNAN;
        end else begin
            rsp_d.result = {sign, exp, man, 16'h0000};    // Zeros, infs, subnormals too
        end
        rsp_d.flags[fpu_pkg::FLAG_NV] = is_snan;
    end

    // Single stage, ready when empty or draining
    assign in_ready_o = !valid_q || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;    // Drained, nothing new
        end
    end

    always_ff @(posedge gated_clk) begin
        if (in_fire) rsp_q <= rsp_d;    // Payload only
    end

    assign out_valid_o = valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: convert/fp32_to_bf16.sv
`timescale 1ns/1ps

module fp32_to_bf16 (
    input  logic                  gated_clk,
    input  logic                  reset,
    // Request side
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  fpu_pkg::fp32_fields_t operand_i,
    // Response side
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fpu_pkg::cvt_rsp_t     rsp_o
);

    logic [fpu_pkg::BF16_W-1:0] truncated;    // Top 16 bits of the input
    logic [fpu_pkg::BF16_W-1:0] rounded;
    logic [fpu_pkg::EXP_W-1:0]  rnd_exp;
    logic                       guard;
    logic                       sticky;
    logic                       round_up;
    logic                       is_nan;
    logic                       is_snan;
    logic                       is_special;
    logic                       inexact;
    logic                       overflow;
    logic                       underflow;
    logic                       in_fire;
    logic                       valid_q;
    fpu_pkg::cvt_rsp_t          rsp_d;
    fpu_pkg::cvt_rsp_t          rsp_q;

    assign truncated = {operand_i.sign, operand_i.exp, operand_i.man[22:16]};
    assign guard     = operand_i.man[15];       // First dropped bit
    assign sticky    = |operand_i.man[14:0];    // Rest of the dropped bits

    // Nearest-even: up above half, or at half with odd lsb
    assign round_up = guard && (sticky || operand_i.man[16]);

    // Carry out of the mantissa bumps the exponent
    // Largest finite input rounds into infinity this way
    assign rounded = truncated + {15'd0, round_up};
    assign rnd_exp = rounded[14:7];

    assign is_special = (operand_i.exp == 8'hFF);    // Inf or NaN
    assign is_nan     = is_special && (operand_i.man != '0);
    assign is_snan    = is_nan && !operand_i.man[22];

    assign inexact   = !is_special && (guard || sticky);
    assign overflow  = !is_special && (rnd_exp == 8'hFF);
    assign underflow = inexact && (rnd_exp == 8'h00);    // Tiny after rounding

    always_comb begin
        rsp_d = '0;
        if (is_nan) begin
            rsp_d.result = {16'h0000, fpu_pkg::BF16_QNAN};
            rsp_d.flags[fpu_pkg::FLAG_NV] = is_snan;
        end else begin
            // Infinities fall through here unchanged, low bits all zero
            rsp_d.result = {16'h0000, rounded};
            rsp_d.flags[fpu_pkg::FLAG_OF] = overflow;
            rsp_d.flags[fpu_pkg::FLAG_UF] = underflow;
            rsp_d.flags[fpu_pkg::FLAG_NX] = inexact || overflow;
        end
    end

    // Same one-deep stage as the widening side
    assign in_ready_o = !valid_q || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge gated_clk) begin
        if (in_fire) begin
            rsp_q <= rsp_d;
        end
    end

    assign out_valid_o = valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: dv/fpu_convert_checker.sv
`timescale 1ns/1ps

module fpu_convert_checker (
    input  logic              gated_clk,
    input  logic              reset,
    input  fpu_pkg::cvt_req_t req_i,
    input  logic              in_valid_i,
    input  logic              in_ready_i,
    input  fpu_pkg::cvt_rsp_t rsp_i,
    input  logic              out_valid_i,
    input  logic              out_ready_i,
    input  logic              fpcsr_clear_i,
    input  logic [3:0]        fpcsr_i,
    output int                checks_o,
    output int                errors_o,
    output int                received_o
);

    fpu_pkg::cvt_rsp_t expect_q[$];    // One entry per accepted request
    int                accept_q[$];    // Cycle of each acceptance
    fpu_pkg::cvt_rsp_t want;
    logic [3:0]        fpcsr_model;
    int                cycle;
    int                checks;
    int                errors;
    int                received;

    assign checks_o   = checks;
    assign errors_o   = errors;
    assign received_o = received;

    // Expected response from the format rules
    function automatic fpu_pkg::cvt_rsp_t convert_ref(input fpu_pkg::cvt_req_t req);
        logic [31:0]       word;
        logic [15:0]       hi;
        logic [15:0]       lo;
        logic [15:0]       bf;
        logic              dropped;
        fpu_pkg::cvt_rsp_t r;
        word = req.operand;
        hi   = word[31:16];
        lo   = word[15:0];
        r    = '0;
        if (req.op == fpu_pkg::OP_WIDEN) begin
            if (lo[14:7] == 8'hFF && lo[6:0] != 7'd0) begin
                r.result = fpu_pkg::FP32_QNAN;
                r.flags[fpu_pkg::FLAG_NV] = !lo[6];    // Signaling NaN
            end else begin
                r.result = {lo, 16'h0000};    // Exact, upper half ignored
            end
        end else if (word[30:23] == 8'hFF && word[22:0] != 23'd0) begin
            r.result = {16'h0000, fpu_pkg::BF16_QNAN};
            r.flags[fpu_pkg::FLAG_NV] = !word[22];
        end else begin
            // Above half goes up, exact half to the even neighbour
            bf = hi;
            if (lo > 16'h8000 || (lo == 16'h8000 && hi[0])) begin
                bf = hi + 16'd1;
            end
            r.result = {16'h0000, bf};
            if (word[30:23] != 8'hFF) begin    // Infinities stay exact
                dropped = (lo != 16'h0000);
                r.flags[fpu_pkg::FLAG_OF] = (bf[14:7] == 8'hFF);
                r.flags[fpu_pkg::FLAG_UF] = dropped && (bf[14:7] == 8'h00);
                r.flags[fpu_pkg::FLAG_NX] = dropped || (bf[14:7] == 8'hFF);
            end
        end
        return r;
    endfunction

    always @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            expect_q.delete();
            accept_q.delete();
            fpcsr_model = 4'd0;
            cycle       = 0;
            checks      = 0;
            errors      = 0;
            received    = 0;
        end else begin
            // Sticky register and model, both as before this edge
            if (fpcsr_i !== fpcsr_model) begin
                $display("ERROR at %0t: fpcsr_o %b, expected %b", $time, fpcsr_i, fpcsr_model);
                errors++;
            end else begin
                checks++;
            end
            if (accept_q.size() > 0 && accept_q[0] == cycle - 1 && !out_valid_i) begin
                $display("ERROR at %0t: no response one cycle after acceptance", $time);
                errors++;
            end
            want = '0;
            if (out_valid_i && out_ready_i) begin
                if (expect_q.size() == 0) begin
                    $display("ERROR at %0t: response with no request outstanding", $time);
                    errors++;
                end else begin
                    want = expect_q.pop_front();
                    void'(accept_q.pop_front());
                    received++;
                    if (rsp_i !== want) begin
                        $display("ERROR at %0t: result %h flags %b, expected %h flags %b",
                                 $time, rsp_i.result, rsp_i.flags, want.result, want.flags);
                        errors++;
                    end else begin
                        checks++;
                    end
                end
            end
            if (fpcsr_clear_i) begin
                fpcsr_model = 4'd0;    // Clear wins
            end else begin
                fpcsr_model = fpcsr_model | want.flags;    // Zero when nothing left
            end
            if (in_valid_i && in_ready_i) begin
                expect_q.push_back(convert_ref(req_i));
                accept_q.push_back(cycle);
            end
            cycle++;
        end
    end

endmodule

// File: dv/fpu_convert_sva.sv
`timescale 1ns/1ps

module fpu_convert_sva (
    input logic              gated_clk,
    input logic              reset,
    input fpu_pkg::cvt_rsp_t rsp_i,
    input logic              out_valid_i,
    input logic              out_ready_i,
    input logic [3:0]        fpcsr_i,
    input logic              w_out_valid_i,    // Widening stage holds a result
    input logic              n_out_valid_i
);

    // Nothing pending or flagged coming out of reset
    a_reset_idle: assert property (@(posedge gated_clk)
        !reset |=> !out_valid_i && fpcsr_i == 4'd0)
        else $error("out_valid_o or fpcsr_o not cleared by reset");

    a_out_stable: assert property (@(posedge gated_clk) disable iff (!reset)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(rsp_i))
        else $error("response dropped or changed while stalled");

    a_one_holder: assert property (@(posedge gated_clk) disable iff (!reset)
        !(w_out_valid_i && n_out_valid_i))
        else $error("both converters hold a result");

endmodule

bind fpu_convert_top fpu_convert_sva u_sva (
    .gated_clk     (gated_clk),
    .reset         (reset),
    .rsp_i         (rsp_o),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .fpcsr_i       (fpcsr_o),
    .w_out_valid_i (w_out_valid),
    .n_out_valid_i (n_out_valid)
);

// File: dv/fpu_convert_tb.sv
`timescale 1ns/1ps

module fpu_convert_tb;

    localparam int TIMEOUT_CYCLES = 64;

    logic              gated_clk;
    logic              reset;
    fpu_pkg::cvt_req_t req;
    logic              in_valid;
    logic              in_ready;
    fpu_pkg::cvt_rsp_t rsp;
    logic              out_valid;
    logic              out_ready;
    logic              fpcsr_clear;
    logic [3:0]        fpcsr;

    logic [31:0] lfsr;
    logic [31:0] r_op;
    logic [31:0] r_word;
    logic        stall_en;    // Random back-pressure on out_ready
    int          sent;
    int          received;
    int          timeouts;
    int          checks;
    int          errors;

    // Signed zeros, infinities, subnormals, quiet and signaling NaNs
    logic [15:0] widen_specials [10] = '{16'h0000, 16'h8000, 16'h7F80, 16'hFF80, 16'h0001,
                                         16'h807F, 16'h7FC0, 16'h7F81, 16'hFFA0, 16'hFF81};
    // Ties, range limits, NaNs
    logic [31:0] narrow_specials [14] = '{32'h3F80_8000, 32'h3F81_8000, 32'h3F80_8001,
                                          32'h7F7F_FFFF, 32'hFF7F_8000, 32'h7F7F_7FFF,
                                          32'h0080_0000, 32'h0080_7FFF, 32'h007F_FFFF,
                                          32'h0000_0001, 32'h8000_8000, 32'h7F80_0001,
                                          32'hFFC0_0001, 32'h7F80_0000};

    fpu_convert_top uut (
        .gated_clk     (gated_clk),
        .reset         (reset),
        .req_i         (req),
        .in_valid_i    (in_valid),
        .in_ready_o    (in_ready),
        .rsp_o         (rsp),
        .out_valid_o   (out_valid),
        .out_ready_i   (out_ready),
        .fpcsr_clear_i (fpcsr_clear),
        .fpcsr_o       (fpcsr)
    );

    fpu_convert_checker u_checker (
        .gated_clk     (gated_clk),
        .reset         (reset),
        .req_i         (req),
        .in_valid_i    (in_valid),
        .in_ready_i    (in_ready),
        .rsp_i         (rsp),
        .out_valid_i   (out_valid),
        .out_ready_i   (out_ready),
        .fpcsr_clear_i (fpcsr_clear),
        .fpcsr_i       (fpcsr),
        .checks_o      (checks),
        .errors_o      (errors),
        .received_o    (received)
    );

    initial begin
        gated_clk = 1'b0;
        forever #10 gated_clk = ~gated_clk;    // 20 ns period
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};    // One step per bit
        end
    endtask

    // Next falling edge, new out_ready
    task automatic tick();
        logic [31:0] stall_bit;
        @(negedge gated_clk);
        if (stall_en) begin
            take_bits(1, stall_bit);
            out_ready = stall_bit[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // Valid stays up after acceptance so requests can stream
    task automatic send(input logic op, input logic [31:0] word);
        int   waited;
        logic taken;
        if (timeouts != 0) return;    // Skip after a timeout
        req      = {op, word};
        in_valid = 1'b1;
        waited   = 0;
        taken    = 1'b0;
        while (!taken && waited < TIMEOUT_CYCLES) begin
            @(posedge gated_clk);
            taken = in_ready;    // Settled since the falling edge
            tick();
            waited++;
        end
        if (taken) begin
            sent++;
        end else begin
            $display("Timeout: request not accepted within %0d cycles", TIMEOUT_CYCLES);
            in_valid = 1'b0;
            timeouts++;
        end
    endtask

    task automatic drain();
        int waited;
        in_valid = 1'b0;
        waited   = 0;
        while (received < sent && waited < TIMEOUT_CYCLES) begin
            tick();
            waited++;
        end
        if (received < sent) begin
            $display("Timeout: %0d responses still missing", sent - received);
            timeouts++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d (%s) finished, %0d errors so far", num, name, errors + timeouts);
    endtask

    initial begin
        reset       = 1'b0;
        req         = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        fpcsr_clear = 1'b0;
        stall_en    = 1'b0;
        lfsr        = 32'h9016_7037;
        sent        = 0;
        timeouts    = 0;
        repeat (4) @(posedge gated_clk);
        @(negedge gated_clk);
        reset = 1'b1;

        foreach (widen_specials[i]) send(fpu_pkg::OP_WIDEN, {16'h0000, widen_specials[i]});
        for (int i = 0; i < 40; i++) begin
            take_bits(32, r_word);
            send(fpu_pkg::OP_WIDEN, r_word);    // Junk in the upper half
        end
        drain();
        report_test(1, "widening");

        for (int i = 0; i < 60; i++) begin
            take_bits(32, r_word);
            if (i % 4 == 0) r_word[15:0] = 16'h8000;    // Exact tie
            send(fpu_pkg::OP_NARROW, r_word);
        end
        drain();
        report_test(2, "narrowing rounding");

        foreach (narrow_specials[i]) send(fpu_pkg::OP_NARROW, narrow_specials[i]);
        drain();
        report_test(3, "narrowing limits");

        stall_en = 1'b1;
        for (int i = 0; i < 120; i++) begin
            take_bits(1, r_op);
            take_bits(32, r_word);
            send(r_op[0], r_word);
        end
        drain();
        stall_en = 1'b0;
        for (int i = 0; i < 40; i++) begin
            take_bits(1, r_op);
            take_bits(32, r_word);
            send(r_op[0], r_word);    // Latency checked by the checker
        end
        drain();
        report_test(4, "mixed stream");

        fpcsr_clear = 1'b1;
        tick();
        fpcsr_clear = 1'b0;
        send(fpu_pkg::OP_WIDEN, 32'h0000_7F81);     // NV
        send(fpu_pkg::OP_NARROW, 32'h0000_0001);    // UF and NX
        drain();
        send(fpu_pkg::OP_NARROW, 32'h7F7F_FFFF);    // OF and NX, leaves on the next edge
        in_valid    = 1'b0;
        fpcsr_clear = 1'b1;                         // Same edge as that transfer
        tick();
        fpcsr_clear = 1'b0;
        drain();
        tick();
        report_test(5, "sticky flags");

        $display("Closing: %0d checks passed, %0d errors, %0d timeouts, %0d sent, %0d received",
                 checks, errors, timeouts, sent, received);
        if (errors == 0 && timeouts == 0 && received == sent && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/cvt_steer.sv
`timescale 1ns/1ps

module cvt_steer (
    input  logic                        gated_clk,
    input  logic                        reset,
    // Outside request
    input  fpu_pkg::cvt_req_t           req_i,
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    // Outside response
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output fpu_pkg::cvt_rsp_t           rsp_o,
    // Sticky status
    input  logic                        fpcsr_clear_i,
    output logic [3:0]                  fpcsr_o,
    // Widening converter
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    output logic [fpu_pkg::BF16_W-1:0]  w_operand_o,
    input  logic                        w_out_valid_i,
    output logic                        w_out_ready_o,
    input  fpu_pkg::cvt_rsp_t           w_rsp_i,
    // Narrowing converter
    output logic                        n_valid_o,
    input  logic                        n_ready_i,
    output fpu_pkg::fp32_fields_t       n_operand_o,
    input  logic                        n_out_valid_i,
    output logic                        n_out_ready_o,
    input  fpu_pkg::cvt_rsp_t           n_rsp_i
);

    logic sel_w;     // Request targets the widening side
    logic w_busy;    // Widening result held past this edge
    logic n_busy;
    logic out_fire;

    assign sel_w = (req_i.op == fpu_pkg::OP_WIDEN);

    // One union word, two views
    assign w_operand_o = req_i.operand.bf16.lo;
    assign n_operand_o = req_i.operand.fp32;

    // A result counts as busy unless it leaves on this edge
    assign w_busy = w_out_valid_i && !out_ready_i;
    assign n_busy = n_out_valid_i && !out_ready_i;

    // Hold a request while the other side still owns the output
    // Keeps at most one converter valid, so order is preserved
    assign w_valid_o = in_valid_i && sel_w && !n_busy;
    assign n_valid_o = in_valid_i && !sel_w && !w_busy;

    always_comb begin
        if (sel_w) begin
            in_ready_o = w_ready_i && !n_busy;
        end else begin
            in_ready_o = n_ready_i && !w_busy;
        end
    end

    // Only the holder sees the downstream ready
    assign w_out_ready_o = out_ready_i && w_out_valid_i;
    assign n_out_ready_o = out_ready_i && n_out_valid_i;

    // Never both valid, plain mux is enough
    assign out_valid_o = w_out_valid_i || n_out_valid_i;
    assign rsp_o       = n_out_valid_i ? n_rsp_i : w_rsp_i;
    assign out_fire    = out_valid_o && out_ready_i;

    // Sticky flags, clear beats set
    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            fpcsr_o <= 4'd0;
        end else if (fpcsr_clear_i) begin
            fpcsr_o <= 4'd0;
        end else if (out_fire) begin
            fpcsr_o <= fpcsr_o | rsp_o.flags;    // Accumulate on transfer only
        end
    end

endmodule

// File: rtl/fpu_convert_top.sv
`timescale 1ns/1ps

module fpu_convert_top (
    input  logic              gated_clk,
    input  logic              reset,
    input  fpu_pkg::cvt_req_t req_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output fpu_pkg::cvt_rsp_t rsp_o,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    input  logic              fpcsr_clear_i,
    output logic [3:0]        fpcsr_o
);

    // Widening link
    logic                       w_valid, w_ready, w_out_valid, w_out_ready;
    logic [fpu_pkg::BF16_W-1:0] w_operand;
    fpu_pkg::cvt_rsp_t          w_rsp;

    // Narrowing link
    logic                       n_valid, n_ready, n_out_valid, n_out_ready;
    fpu_pkg::fp32_fields_t      n_operand;
    fpu_pkg::cvt_rsp_t          n_rsp;

    cvt_steer u_steer (
        .gated_clk     (gated_clk),
        .reset         (reset),
        .req_i         (req_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .rsp_o         (rsp_o),
        .fpcsr_clear_i (fpcsr_clear_i),
        .fpcsr_o       (fpcsr_o),
        .w_valid_o     (w_valid),
        .w_ready_i     (w_ready),
        .w_operand_o   (w_operand),
        .w_out_valid_i (w_out_valid),
        .w_out_ready_o (w_out_ready),
        .w_rsp_i       (w_rsp),
        .n_valid_o     (n_valid),
        .n_ready_i     (n_ready),
        .n_operand_o   (n_operand),
        .n_out_valid_i (n_out_valid),
        .n_out_ready_o (n_out_ready),
        .n_rsp_i       (n_rsp)
    );

    bf16_to_fp32 u_widen (
        .gated_clk   (gated_clk),
        .reset       (reset),
        .in_valid_i  (w_valid),
        .in_ready_o  (w_ready),
        .operand_i   (w_operand),
        .out_valid_o (w_out_valid),
        .out_ready_i (w_out_ready),
        .rsp_o       (w_rsp)
    );

    fp32_to_bf16 u_narrow (
        .gated_clk   (gated_clk),
        .reset       (reset),
        .in_valid_i  (n_valid),
        .in_ready_o  (n_ready),
        .operand_i   (n_operand),
        .out_valid_o (n_out_valid),
        .out_ready_i (n_out_ready),
        .rsp_o       (n_rsp)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f sources.f --top-module fpu_convert_tb \
    -o fpu_convert_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fpu_convert_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// File: sources.f
common/fpu_pkg.sv
convert/bf16_to_fp32.sv
convert/fp32_to_bf16.sv
rtl/cvt_steer.sv
rtl/fpu_convert_top.sv
dv/fpu_convert_sva.sv
dv/fpu_convert_checker.sv
dv/fpu_convert_tb.sv
